// ==== hw/chronos_cm_pkg.sv ====
package chronos_cm_pkg;

   // Core enqueue ports
   localparam int NUM_SI     = 2;
   localparam int LOG_NUM_SI = (NUM_SI > 1) ? $clog2(NUM_SI) : 1;

   // Location of a child task
   localparam int LOG_N_TILES = 2;
   localparam int LOG_TQ_SIZE = 4;
   localparam int EPOCH_WIDTH = 8;

   // Parent slot and child index
   localparam int LOG_CQ_SLICE_SIZE     = 2;
   localparam int LOG_CHILDREN_PER_TASK = 2;
   localparam int N_CHILD_ENTRIES       = 2 ** (LOG_CQ_SLICE_SIZE + LOG_CHILDREN_PER_TASK);

   localparam int TASK_WIDTH = 32;

   typedef logic [LOG_N_TILES-1:0]       tile_id_t;
   typedef logic [LOG_TQ_SIZE-1:0]       tq_slot_t;
   typedef logic [EPOCH_WIDTH-1:0]       epoch_t;
   typedef logic [LOG_CQ_SLICE_SIZE-1:0] cq_slot_t;
   // One extra bit so a full child count fits
   typedef logic [LOG_CHILDREN_PER_TASK:0] child_id_t;
   typedef logic [TASK_WIDTH-1:0]          task_t;

   typedef struct packed {
      cq_slot_t                         cq_slot;
      logic [LOG_CHILDREN_PER_TASK-1:0] child;
   } child_addr_t;

   typedef enum logic [1:0] {CHILD_SENT, CHILD_ACKED, CHILD_UNTRACKED} child_state_t;

   typedef struct packed {
      tile_id_t tile;
      tq_slot_t slot;
      epoch_t   epoch;
   } child_loc_t;

   typedef struct packed {
      child_state_t state;
      child_loc_t   loc;
   } child_ptr_t;

   typedef enum logic [1:0] {WALK_IDLE, WALK_READ, WALK_CHECK, WALK_DONE} walk_state_t;

endpackage

// ==== hw/child_mem_if.sv ====
// Write port of the children array, always accepted
interface child_wr_if;
   import chronos_cm_pkg::*;

   logic        en;
   child_addr_t addr;
   child_ptr_t  ptr;

   modport writer (output en, addr, ptr);
   modport store (input en, addr, ptr);
endinterface

// Read port, ptr is valid the cycle after en
interface child_rd_if;
   import chronos_cm_pkg::*;

   logic        en;
   child_addr_t addr;
   child_ptr_t  ptr;
   // Reader is waiting on this entry, keep reloading it
   logic        stalled;

   modport reader (output en, addr, stalled, input ptr);
   modport store (input en, addr, stalled, output ptr);
endinterface

// ==== hw/cm_update_decode.sv ====
module cm_update_decode (
   input  logic                                                   clk,
   input  logic                                                   rstn,
   input  logic                  [chronos_cm_pkg::NUM_SI-1:0]     s_wvalid,
   output logic                  [chronos_cm_pkg::NUM_SI-1:0]     s_wready,
   input  chronos_cm_pkg::task_t [chronos_cm_pkg::NUM_SI-1:0]     s_wdata,
   input  logic                  [chronos_cm_pkg::NUM_SI-1:0]     s_enq_untied,
   input  chronos_cm_pkg::cq_slot_t  [chronos_cm_pkg::NUM_SI-1:0] s_cq_slot,
   input  chronos_cm_pkg::child_id_t [chronos_cm_pkg::NUM_SI-1:0] s_child_id,
   output logic                                                   task_enq_valid,
   input  logic                                                   task_enq_ready,
   output chronos_cm_pkg::task_t                                  task_enq_data,
   output logic                                                   task_enq_tied,
   output chronos_cm_pkg::cq_slot_t                               task_enq_resp_cq_slot,
   output chronos_cm_pkg::child_id_t                              task_enq_resp_child_id,
   input  logic                                                   task_resp_valid,
   input  chronos_cm_pkg::cq_slot_t                               task_resp_cq_slot,
   input  chronos_cm_pkg::child_id_t                              task_resp_child_id,
   input  chronos_cm_pkg::child_loc_t                             task_resp_loc,
   child_wr_if.writer                                             wr
);
   import chronos_cm_pkg::*;

   logic [NUM_SI-1:0]     untied_vec;
   logic [LOG_NUM_SI-1:0] sel;
   logic                  can_take;
   logic                  take_enq;

   function automatic logic [LOG_NUM_SI-1:0] lowest_set(input logic [NUM_SI-1:0] vec);
      logic [LOG_NUM_SI-1:0] idx;
      idx = '0;
      for (int i = NUM_SI - 1; i >= 0; i--) begin
         if (vec[i]) begin
            idx = LOG_NUM_SI'(i);
         end
      end
      return idx;
   endfunction

   // Untied tasks go first since they never need an array entry
   assign untied_vec = s_wvalid & s_enq_untied;
   assign sel        = (|untied_vec) ? lowest_set(untied_vec) : lowest_set(s_wvalid);

   // A response owns the write port this cycle
   assign can_take = !task_enq_valid || task_enq_ready;
   assign take_enq = can_take && !task_resp_valid && (|s_wvalid);

   always_comb begin
      s_wready = '0;
      if (take_enq) begin
         s_wready[sel] = 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         task_enq_valid <= 1'b0;
      end else if (take_enq) begin
         task_enq_valid <= 1'b1;
      end else if (task_enq_ready) begin
         task_enq_valid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (take_enq) begin
         task_enq_data          <= s_wdata[sel];
         task_enq_tied          <= !s_enq_untied[sel];
         task_enq_resp_cq_slot  <= s_cq_slot[sel];
         task_enq_resp_child_id <= s_child_id[sel];
      end
   end

   // Array update
   always_comb begin
      wr.en   = 1'b0;
      wr.addr = '0;
      wr.ptr  = '0;
      if (task_resp_valid) begin
         wr.en           = 1'b1;
         wr.addr.cq_slot = task_resp_cq_slot;
         wr.addr.child   = task_resp_child_id[LOG_CHILDREN_PER_TASK-1:0];
         wr.ptr.state    = CHILD_ACKED;
         wr.ptr.loc      = task_resp_loc;
      end else if (take_enq && !s_enq_untied[sel]) begin
         wr.en           = 1'b1;
         wr.addr.cq_slot = s_cq_slot[sel];
         wr.addr.child   = s_child_id[sel][LOG_CHILDREN_PER_TASK-1:0];
         wr.ptr.state    = CHILD_SENT;
      end
   end

endmodule

// ==== hw/cm_children_array.sv ====
module cm_children_array (
   input logic        clk,
   input logic        rstn,
   child_wr_if.store  wr,
   child_rd_if.store  rd
);
   import chronos_cm_pkg::*;

   child_ptr_t                 mem [N_CHILD_ENTRIES];
   logic [N_CHILD_ENTRIES-1:0] track;
   child_ptr_t                 stored;
   child_ptr_t                 rd_q;
   logic                       bypass;

   always_ff @(posedge clk) begin
      if (wr.en) begin
         mem[wr.addr] <= wr.ptr;
      end
   end

   // Entries never written read back as untracked
   always_ff @(posedge clk) begin
      if (!rstn) begin
         track <= '0;
      end else if (wr.en) begin
         track[wr.addr] <= 1'b1;
      end
   end

   always_comb begin
      stored = mem[rd.addr];
      if (!track[rd.addr]) begin
         stored.state = CHILD_UNTRACKED;
      end
   end

   // Same-cycle write to the read address wins
   assign bypass = wr.en && (wr.addr == rd.addr);

   always_ff @(posedge clk) begin
      if (rd.en || rd.stalled) begin
         rd_q <= bypass ? wr.ptr : stored;
      end
   end

   assign rd.ptr = rd_q;

endmodule

// ==== hw/cm_cut_ties_walker.sv ====
module cm_cut_ties_walker (
   input  logic                       clk,
   input  logic                       rstn,
   input  logic                       cq_cut_ties_valid,
   output logic                       cq_cut_ties_ready,
   input  chronos_cm_pkg::cq_slot_t   cq_cut_ties_cq_slot,
   input  chronos_cm_pkg::child_id_t  cq_cut_ties_count,
   child_rd_if.reader                 rd,
   output logic                       msg_valid,
   output chronos_cm_pkg::child_loc_t msg_loc,
   output logic                       ack_valid,
   input  logic                       msg_busy
);
   import chronos_cm_pkg::*;

   walk_state_t state;
   walk_state_t state_next;
   cq_slot_t    cur_slot;
   child_id_t   cur_idx;
   child_id_t   cur_count;
   child_id_t   next_idx;
   logic        last_child;
   logic        child_done;

   assign next_idx   = cur_idx + 1'b1;
   assign last_child = (next_idx == cur_count);

   assign cq_cut_ties_ready = (state == WALK_IDLE);

   // Address also carries the parent slot back to the ack
   assign rd.en   = (state == WALK_READ);
   assign rd.addr = '{cq_slot: cur_slot, child: cur_idx[LOG_CHILDREN_PER_TASK-1:0]};
   assign msg_loc = rd.ptr.loc;

   always_comb begin
      state_next = state;
      msg_valid  = 1'b0;
      ack_valid  = 1'b0;
      child_done = 1'b0;
      rd.stalled = 1'b0;
      case (state)
         WALK_IDLE: begin
            if (cq_cut_ties_valid) begin
               state_next = (cq_cut_ties_count == '0) ? WALK_DONE : WALK_READ;
            end
         end
         WALK_READ: begin
            state_next = WALK_CHECK;
         end
         WALK_CHECK: begin
            case (rd.ptr.state)
               // Hold here until the response lands in the array
               CHILD_SENT: rd.stalled = 1'b1;
               CHILD_ACKED: begin
                  if (msg_busy) begin
                     rd.stalled = 1'b1;
                  end else begin
                     msg_valid  = 1'b1;
                     child_done = 1'b1;
                  end
               end
               default: child_done = 1'b1;
            endcase
            if (child_done) begin
               state_next = last_child ? WALK_DONE : WALK_READ;
            end
         end
         WALK_DONE: begin
            // Ack only once the last message has left
            if (!msg_busy) begin
               ack_valid  = 1'b1;
               state_next = WALK_IDLE;
            end
         end
         default: state_next = WALK_IDLE;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         state <= WALK_IDLE;
      end else begin
         state <= state_next;
      end
   end

   always_ff @(posedge clk) begin
      if (cq_cut_ties_valid && cq_cut_ties_ready) begin
         cur_slot  <= cq_cut_ties_cq_slot;
         cur_count <= cq_cut_ties_count;
         cur_idx   <= '0;
      end else if (child_done) begin
         cur_idx <= next_idx;
      end
   end

endmodule

// ==== hw/cm_tile_msg_out.sv ====
module cm_tile_msg_out (
   input  logic                       clk,
   input  logic                       rstn,
   input  logic                       msg_valid,
   input  chronos_cm_pkg::child_loc_t msg_loc,
   input  logic                       ack_valid,
   input  chronos_cm_pkg::cq_slot_t   ack_cq_slot,
   output logic                       msg_busy,
   output logic                       cut_ties_valid,
   output chronos_cm_pkg::child_loc_t cut_ties_loc,
   input  logic                       cut_ties_ready,
   output logic                       cut_ties_ack_valid,
   output chronos_cm_pkg::cq_slot_t   cut_ties_ack_cq_slot,
   input  logic                       cut_ties_ack_ready
);

   // A slot leaving this cycle can be refilled at the same edge
   assign msg_busy = (cut_ties_valid && !cut_ties_ready) ||
                     (cut_ties_ack_valid && !cut_ties_ack_ready);

   always_ff @(posedge clk) begin
      if (!rstn) begin
         cut_ties_valid     <= 1'b0;
         cut_ties_ack_valid <= 1'b0;
      end else begin
         if (msg_valid) begin
            cut_ties_valid <= 1'b1;
         end else if (cut_ties_ready) begin
            cut_ties_valid <= 1'b0;
         end
         if (ack_valid) begin
            cut_ties_ack_valid <= 1'b1;
         end else if (cut_ties_ack_ready) begin
            cut_ties_ack_valid <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (msg_valid) begin
         cut_ties_loc <= msg_loc;
      end
      if (ack_valid) begin
         cut_ties_ack_cq_slot <= ack_cq_slot;
      end
   end

endmodule

// ==== hw/child_manager.sv ====
module child_manager (
   input  logic                                                   clk,
   input  logic                                                   rstn,
   // Core side
   input  logic                  [chronos_cm_pkg::NUM_SI-1:0]     s_wvalid,
   output logic                  [chronos_cm_pkg::NUM_SI-1:0]     s_wready,
   input  chronos_cm_pkg::task_t [chronos_cm_pkg::NUM_SI-1:0]     s_wdata,
   input  logic                  [chronos_cm_pkg::NUM_SI-1:0]     s_enq_untied,
   input  chronos_cm_pkg::cq_slot_t  [chronos_cm_pkg::NUM_SI-1:0] s_cq_slot,
   input  chronos_cm_pkg::child_id_t [chronos_cm_pkg::NUM_SI-1:0] s_child_id,
   // Enqueue to task queue
   output logic                                                   task_enq_valid,
   input  logic                                                   task_enq_ready,
   output chronos_cm_pkg::task_t                                  task_enq_data,
   output logic                                                   task_enq_tied,
   output chronos_cm_pkg::cq_slot_t                               task_enq_resp_cq_slot,
   output chronos_cm_pkg::child_id_t                              task_enq_resp_child_id,
   // Task queue response
   input  logic                                                   task_resp_valid,
   output logic                                                   task_resp_ready,
   input  chronos_cm_pkg::cq_slot_t                               task_resp_cq_slot,
   input  chronos_cm_pkg::child_id_t                              task_resp_child_id,
   input  chronos_cm_pkg::child_loc_t                             task_resp_loc,
   // Cut-ties request from the CQ
   input  logic                                                   cq_cut_ties_valid,
   output logic                                                   cq_cut_ties_ready,
   input  chronos_cm_pkg::cq_slot_t                               cq_cut_ties_cq_slot,
   input  chronos_cm_pkg::child_id_t                              cq_cut_ties_count,
   // Tile message and CQ ack
   output logic                                                   cut_ties_valid,
   input  logic                                                   cut_ties_ready,
   output chronos_cm_pkg::child_loc_t                             cut_ties_loc,
   output logic                                                   cut_ties_ack_valid,
   input  logic                                                   cut_ties_ack_ready,
   output chronos_cm_pkg::cq_slot_t                               cut_ties_ack_cq_slot
);
   import chronos_cm_pkg::*;

   logic       msg_valid;
   child_loc_t msg_loc;
   logic       ack_valid;
   logic       msg_busy;

   child_wr_if wr_if ();
   child_rd_if rd_if ();

   // Responses always win the write port
   assign task_resp_ready = 1'b1;

   cm_update_decode i_update_decode (
      .clk                    (clk),
      .rstn                   (rstn),
      .s_wvalid               (s_wvalid),
      .s_wready               (s_wready),
      .s_wdata                (s_wdata),
      .s_enq_untied           (s_enq_untied),
      .s_cq_slot              (s_cq_slot),
      .s_child_id             (s_child_id),
      .task_enq_valid         (task_enq_valid),
      .task_enq_ready         (task_enq_ready),
      .task_enq_data          (task_enq_data),
      .task_enq_tied          (task_enq_tied),
      .task_enq_resp_cq_slot  (task_enq_resp_cq_slot),
      .task_enq_resp_child_id (task_enq_resp_child_id),
      .task_resp_valid        (task_resp_valid),
      .task_resp_cq_slot      (task_resp_cq_slot),
      .task_resp_child_id     (task_resp_child_id),
      .task_resp_loc          (task_resp_loc),
      .wr                     (wr_if.writer)
   );

   cm_children_array i_children_array (
      .clk  (clk),
      .rstn (rstn),
      .wr   (wr_if.store),
      .rd   (rd_if.store)
   );

   cm_cut_ties_walker i_cut_ties_walker (
      .clk                 (clk),
      .rstn                (rstn),
      .cq_cut_ties_valid   (cq_cut_ties_valid),
      .cq_cut_ties_ready   (cq_cut_ties_ready),
      .cq_cut_ties_cq_slot (cq_cut_ties_cq_slot),
      .cq_cut_ties_count   (cq_cut_ties_count),
      .rd                  (rd_if.reader),
      .msg_valid           (msg_valid),
      .msg_loc             (msg_loc),
      .ack_valid           (ack_valid),
      .msg_busy            (msg_busy)
   );

   // Walker read address still holds the parent slot when it acks
   cm_tile_msg_out i_tile_msg_out (
      .clk                  (clk),
      .rstn                 (rstn),
      .msg_valid            (msg_valid),
      .msg_loc              (msg_loc),
      .ack_valid            (ack_valid),
      .ack_cq_slot          (rd_if.addr.cq_slot),
      .msg_busy             (msg_busy),
      .cut_ties_valid       (cut_ties_valid),
      .cut_ties_loc         (cut_ties_loc),
      .cut_ties_ready       (cut_ties_ready),
      .cut_ties_ack_valid   (cut_ties_ack_valid),
      .cut_ties_ack_cq_slot (cut_ties_ack_cq_slot),
      .cut_ties_ack_ready   (cut_ties_ack_ready)
   );

endmodule

// ==== sim/tb_clock.sv ====
module tb_clock (
   output logic clk,
   output logic rstn
);
   timeunit 1ns;
   timeprecision 100ps;

   initial clk = 1'b0;
   always #2 clk = ~clk;

   // Reset held for four rising edges
   initial begin
      rstn = 1'b0;
      repeat (4) @(posedge clk);
      #1 rstn = 1'b1;
   end
endmodule

// ==== sim/child_manager_checker.sv ====
module child_manager_checker (
   input logic                       clk,
   input logic                       rstn,
   input logic [chronos_cm_pkg::NUM_SI-1:0] s_wready,
   input logic                       task_resp_valid,
   input logic                       task_enq_valid,
   input logic                       task_enq_ready,
   input chronos_cm_pkg::task_t      task_enq_data,
   input logic                       cut_ties_valid,
   input logic                       cut_ties_ready,
   input chronos_cm_pkg::child_loc_t cut_ties_loc,
   input logic                       cut_ties_ack_valid,
   input logic                       cut_ties_ack_ready,
   input chronos_cm_pkg::cq_slot_t   cut_ties_ack_cq_slot
);
   timeunit 1ns;
   timeprecision 100ps;

   a_wready_onehot: assert property (@(posedge clk) disable iff (!rstn)
      $onehot0(s_wready)) else $error("s_wready has more than one bit set");

   a_resp_blocks_enq: assert property (@(posedge clk) disable iff (!rstn)
      task_resp_valid |-> (s_wready == '0)) else $error("s_wready high during a response");

   a_enq_hold: assert property (@(posedge clk) disable iff (!rstn)
      task_enq_valid && !task_enq_ready |=> task_enq_valid && $stable(task_enq_data))
      else $error("task_enq dropped or changed before ready");

   a_msg_hold: assert property (@(posedge clk) disable iff (!rstn)
      cut_ties_valid && !cut_ties_ready |=> cut_ties_valid && $stable(cut_ties_loc))
      else $error("cut_ties dropped or changed before ready");

   a_ack_hold: assert property (@(posedge clk) disable iff (!rstn)
      cut_ties_ack_valid && !cut_ties_ack_ready |=>
         cut_ties_ack_valid && $stable(cut_ties_ack_cq_slot))
      else $error("cut_ties_ack dropped or changed before ready");
endmodule

bind child_manager child_manager_checker i_checker (.*);

// ==== sim/tb_child_manager.sv ====
module tb_child_manager;
   timeunit 1ns;
   timeprecision 100ps;
   import chronos_cm_pkg::*;

   localparam int TIMEOUT = 3000;

   logic clk;
   logic rstn;
   logic [NUM_SI-1:0] s_wvalid;
   logic [NUM_SI-1:0] s_wready;
   task_t [NUM_SI-1:0] s_wdata;
   logic [NUM_SI-1:0] s_enq_untied;
   cq_slot_t [NUM_SI-1:0] s_cq_slot;
   child_id_t [NUM_SI-1:0] s_child_id;
   logic task_enq_valid;
   logic task_enq_ready;
   task_t task_enq_data;
   logic task_enq_tied;
   cq_slot_t task_enq_resp_cq_slot;
   child_id_t task_enq_resp_child_id;
   logic task_resp_valid;
   logic task_resp_ready;
   cq_slot_t task_resp_cq_slot;
   child_id_t task_resp_child_id;
   child_loc_t task_resp_loc;
   logic cq_cut_ties_valid;
   logic cq_cut_ties_ready;
   cq_slot_t cq_cut_ties_cq_slot;
   child_id_t cq_cut_ties_count;
   logic cut_ties_valid;
   logic cut_ties_ready;
   child_loc_t cut_ties_loc;
   logic cut_ties_ack_valid;
   logic cut_ties_ack_ready;
   cq_slot_t cut_ties_ack_cq_slot;

   // Reference model state
   child_ptr_t model [N_CHILD_ENTRIES];
   task_t exp_data [$];
   logic exp_tied [$];
   cq_slot_t exp_slot [$];
   child_id_t exp_id [$];
   cq_slot_t pend_slot [$];
   child_id_t pend_id [$];
   child_loc_t pend_loc [$];
   int pend_due [$];
   logic [NUM_SI-1:0] port_taken;
   logic [31:0] rng_state = 32'ha709_9051;
   int cycle;
   int errors;
   int checks;
   int msgs_seen;
   int acks_seen;
   int resp_delay_min;
   bit gen_on;
   bit inj_valid;
   cq_slot_t inj_slot;
   child_id_t inj_id;
   bit req_pending;
   bit walk_active;
   cq_slot_t walk_slot;
   int walk_count;
   int walk_idx;

   tb_clock i_tb_clock (.clk(clk), .rstn(rstn));

   child_manager i_child_manager (.*);

   function automatic logic [31:0] next_random();
      rng_state ^= rng_state << 13;
      rng_state ^= rng_state >> 17;
      rng_state ^= rng_state << 5;
      return rng_state;
   endfunction

   function automatic int addr_of(cq_slot_t slot, int child);
      return int'(slot) * (1 << LOG_CHILDREN_PER_TASK) + (child % (1 << LOG_CHILDREN_PER_TASK));
   endfunction

   task automatic compare_task(string name, task_t got, task_t exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("ERROR %0t %s: got %h expected %h", $time, name, got, exp);
      end
   endtask

   task automatic compare_loc(string name, child_loc_t got, child_loc_t exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("ERROR %0t %s: got %h expected %h", $time, name, got, exp);
      end
   endtask

   task automatic compare_slot(string name, cq_slot_t got, cq_slot_t exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("ERROR %0t %s: got %h expected %h", $time, name, got, exp);
      end
   endtask

   task automatic compare_id(string name, child_id_t got, child_id_t exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("ERROR %0t %s: got %h expected %h", $time, name, got, exp);
      end
   endtask

   task automatic compare_ready(string name, logic [NUM_SI-1:0] got, logic [NUM_SI-1:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("ERROR %0t %s: got %b expected %b", $time, name, got, exp);
      end
   endtask

   task automatic compare_bit(string name, logic got, logic exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("ERROR %0t %s: got %b expected %b", $time, name, got, exp);
      end
   endtask

   task automatic report_failure(string what);
      errors++;
      $display("%0t %s", $time, what);
   endtask

   task automatic finish_failed();
      $display("Done: errors found");
      $finish;
   endtask

   task automatic abort_on_timeout(string what);
      $display("%0t Timeout while waiting for %s", $time, what);
      $display("Checks: %0d, errors: %0d", checks, errors + 1);
      finish_failed();
   endtask

   // Children that were never written are passed over by the walker
   task automatic skip_untracked();
      while (walk_idx < walk_count &&
             model[addr_of(walk_slot, walk_idx)].state == CHILD_UNTRACKED) begin
         walk_idx++;
      end
   endtask

   task automatic check_message();
      msgs_seen++;
      if (!walk_active) begin
         report_failure("Cut-ties message with no request in progress");
         return;
      end
      skip_untracked();
      if (walk_idx >= walk_count) begin
         report_failure("Cut-ties message after the last child of the request");
      end else if (model[addr_of(walk_slot, walk_idx)].state != CHILD_ACKED) begin
         report_failure("Cut-ties message for a child that is not acked");
         walk_idx++;
      end else begin
         compare_loc("cut_ties_loc", cut_ties_loc, model[addr_of(walk_slot, walk_idx)].loc);
         walk_idx++;
      end
   endtask

   task automatic check_ack();
      acks_seen++;
      if (!walk_active) begin
         report_failure("Cut-ties ack with no request in progress");
         return;
      end
      skip_untracked();
      if (walk_idx != walk_count) begin
         report_failure("Cut-ties ack before every acked child got its message");
      end
      compare_slot("cut_ties_ack_cq_slot", cut_ties_ack_cq_slot, walk_slot);
      walk_active = 0;
   endtask

   task automatic drive_inputs();
      for (int i = 0; i < NUM_SI; i++) begin
         if (!(s_wvalid[i] && !port_taken[i])) begin
            s_wvalid[i]     = gen_on && (next_random() % 3 != 0);
            s_wdata[i]      = next_random();
            s_enq_untied[i] = (next_random() % 2) != 0;
            s_cq_slot[i]    = cq_slot_t'(next_random());
            // Child 3 stays untracked in the random phase
            s_child_id[i]   = child_id_t'(next_random() % 3);
         end
      end
      port_taken = '0;
      if (inj_valid && !s_wvalid[0]) begin
         s_wvalid[0]     = 1'b1;
         s_wdata[0]      = next_random();
         s_enq_untied[0] = 1'b0;
         s_cq_slot[0]    = inj_slot;
         s_child_id[0]   = inj_id;
         inj_valid       = 0;
      end
      task_enq_ready     = (next_random() % 4 != 0);
      cut_ties_ready     = (next_random() % 3 != 0);
      cut_ties_ack_ready = (next_random() % 3 != 0);
      task_resp_valid    = 1'b0;
      if (pend_due.size() > 0 && pend_due[0] <= cycle) begin
         task_resp_valid    = 1'b1;
         task_resp_cq_slot  = pend_slot.pop_front();
         task_resp_child_id = pend_id.pop_front();
         task_resp_loc      = pend_loc.pop_front();
         void'(pend_due.pop_front());
      end
      cq_cut_ties_valid = req_pending;
   endtask

   task automatic sample_outputs();
      logic [NUM_SI-1:0] exp_rdy;
      logic [NUM_SI-1:0] untied_valid;
      logic enq_held;
      logic tied_now;
      cq_slot_t slot_now;
      child_id_t id_now;
      int a;
      // The enqueue register holds at most one accepted task
      enq_held = (exp_data.size() > 0);
      compare_bit("task_enq_valid", task_enq_valid, enq_held);
      compare_bit("task_resp_ready", task_resp_ready, 1'b1);
      // Expected arbitration from the selection rules
      exp_rdy = '0;
      untied_valid = s_wvalid & s_enq_untied;
      if (!task_resp_valid && (!enq_held || task_enq_ready) && (|s_wvalid)) begin
         for (int i = NUM_SI - 1; i >= 0; i--) begin
            if ((|untied_valid) ? untied_valid[i] : s_wvalid[i]) begin
               exp_rdy = '0;
               exp_rdy[i] = 1'b1;
            end
         end
      end
      compare_ready("s_wready", s_wready, exp_rdy);
      if (task_enq_valid && task_enq_ready) begin
         if (exp_data.size() == 0) begin
            report_failure("Enqueue output with no accepted task");
         end else begin
            tied_now = exp_tied.pop_front();
            slot_now = exp_slot.pop_front();
            id_now   = exp_id.pop_front();
            compare_task("task_enq_data", task_enq_data, exp_data.pop_front());
            compare_bit("task_enq_tied", task_enq_tied, tied_now);
            compare_slot("task_enq_resp_cq_slot", task_enq_resp_cq_slot, slot_now);
            compare_id("task_enq_resp_child_id", task_enq_resp_child_id, id_now);
            if (tied_now) begin
               pend_slot.push_back(slot_now);
               pend_id.push_back(id_now);
               pend_loc.push_back(child_loc_t'(next_random()));
               pend_due.push_back(cycle + resp_delay_min + int'(next_random() % 12));
            end
         end
      end
      // Messages read the array before this cycle's write
      if (cut_ties_valid && cut_ties_ready) begin
         check_message();
      end
      if (cut_ties_ack_valid && cut_ties_ack_ready) begin
         check_ack();
      end
      for (int i = 0; i < NUM_SI; i++) begin
         if (s_wvalid[i] && s_wready[i]) begin
            port_taken[i] = 1'b1;
            exp_data.push_back(s_wdata[i]);
            exp_tied.push_back(!s_enq_untied[i]);
            exp_slot.push_back(s_cq_slot[i]);
            exp_id.push_back(s_child_id[i]);
            if (!s_enq_untied[i]) begin
               a = addr_of(s_cq_slot[i], int'(s_child_id[i]));
               model[a].state = CHILD_SENT;
            end
         end
      end
      if (task_resp_valid) begin
         a = addr_of(task_resp_cq_slot, int'(task_resp_child_id));
         model[a].state = CHILD_ACKED;
         model[a].loc   = task_resp_loc;
      end
      if (cq_cut_ties_valid && cq_cut_ties_ready) begin
         req_pending = 0;
         walk_active = 1;
         walk_slot   = cq_cut_ties_cq_slot;
         walk_count  = int'(cq_cut_ties_count);
         walk_idx    = 0;
      end
   endtask

   task automatic run_cycle();
      @(posedge clk);
      cycle++;
      #1;
      drive_inputs();
      #2;
      sample_outputs();
   endtask

   task automatic do_cut_ties(cq_slot_t slot, int count);
      int n;
      req_pending = 1;
      cq_cut_ties_cq_slot = slot;
      cq_cut_ties_count = child_id_t'(count);
      n = 0;
      while (req_pending || walk_active) begin
         run_cycle();
         n++;
         if (n > TIMEOUT) begin
            abort_on_timeout("the cut-ties ack");
         end
      end
   endtask

   initial begin
      int n;
      s_wvalid = '0;
      s_wdata = '0;
      s_enq_untied = '0;
      s_cq_slot = '0;
      s_child_id = '0;
      task_enq_ready = 1'b0;
      task_resp_valid = 1'b0;
      task_resp_cq_slot = '0;
      task_resp_child_id = '0;
      task_resp_loc = '0;
      cq_cut_ties_valid = 1'b0;
      cq_cut_ties_cq_slot = '0;
      cq_cut_ties_count = '0;
      cut_ties_ready = 1'b0;
      cut_ties_ack_ready = 1'b0;
      port_taken = '0;
      resp_delay_min = 1;
      for (int i = 0; i < N_CHILD_ENTRIES; i++) begin
         model[i] = '{state: CHILD_UNTRACKED, loc: '0};
      end
      n = 0;
      while (rstn !== 1'b1) begin
         @(posedge clk);
         n++;
         if (n > 20) begin
            abort_on_timeout("the end of reset");
         end
      end

      // Random enqueue traffic with back-pressure and responses
      gen_on = 1;
      repeat (400) run_cycle();
      gen_on = 0;
      n = 0;
      while (s_wvalid != '0 || exp_data.size() > 0 || pend_due.size() > 0 || task_resp_valid) begin
         run_cycle();
         n++;
         if (n > TIMEOUT) begin
            abort_on_timeout("the enqueue traffic to drain");
         end
      end

      // Walks over settled children, the first with a zero count
      do_cut_ties(cq_slot_t'(next_random()), 0);
      for (int r = 0; r < 12; r++) begin
         do_cut_ties(cq_slot_t'(next_random()), int'(next_random() % 5));
      end

      // Request issued while child 3 of slot 2 is still in flight
      resp_delay_min = 30;
      inj_slot = 2'd2;
      inj_id = 3'd3;
      inj_valid = 1;
      n = 0;
      while (inj_valid || s_wvalid != '0 || exp_data.size() > 0) begin
         run_cycle();
         n++;
         if (n > TIMEOUT) begin
            abort_on_timeout("the tied enqueue to leave");
         end
      end
      do_cut_ties(2'd2, 4);
      resp_delay_min = 1;
      repeat (5) run_cycle();

      $display("Checks: %0d, messages: %0d, acks: %0d, errors: %0d",
               checks, msgs_seen, acks_seen, errors);
      if (errors == 0) begin
         $display("Done: no errors");
         $finish;
      end else begin
         finish_failed();
      end
   end
endmodule

// ==== child_manager.f ====
hw/chronos_cm_pkg.sv
hw/child_mem_if.sv
hw/cm_update_decode.sv
hw/cm_children_array.sv
hw/cm_cut_ties_walker.sv
hw/cm_tile_msg_out.sv
hw/child_manager.sv
sim/tb_clock.sv
sim/child_manager_checker.sv
sim/tb_child_manager.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the child manager testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f child_manager.f \
   --top-module tb_child_manager -Mdir obj_dir -o sim_child_manager
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/sim_child_manager > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "Done: no errors" sim.log; then
   exit 0
fi
exit 1
